// File: hdl/ccm_pkg.sv
// Shared widths and types for the CCM. Word-addressed banks of 64 bits, rows fixed at build time.
package ccm_pkg;

	// Row address bits per bank.
	localparam int ccm_row_w = 11;
	localparam int ccm_depth = 1 << ccm_row_w; // Rows per bank.

	// Byte address seen both as a flat word and as bank fields.
	typedef union packed {
		logic [63:0] flat;
		struct packed {
			logic [63-ccm_row_w-4:0] upper; // Unused.
			logic [ccm_row_w-1:0]    row;
			logic                    bank;   // Bank holding the first word.
			logic [2:0]              offset; // Byte inside the word.
		} f;
	} ccm_addr_u;

	// One access from the slave front end to the aligner.
	typedef struct packed {
		ccm_addr_u   addr;
		logic [63:0] wdata;
		logic [7:0]  wstrb;
		logic        wen;
		logic        ren;
	} ccm_req_t;

	// One aligned access to a single bank.
	typedef struct packed {
		logic [ccm_row_w-1:0] row;
		logic [63:0]          wdata;
		logic [7:0]           wstrb;
		logic                 wen;
		logic                 ren;
	} ccm_bank_req_t;

endpackage

// File: hdl/ccm_axi_slave.sv
// AXI4-Lite slave front end: one write and one read in flight, OKAY responses only, no bursts.
module ccm_axi_slave
	import ccm_pkg::*;
(
	input  logic        CLK,
	input  logic        reset,

	input  logic [63:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [63:0] wdata,
	input  logic [7:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,

	input  logic [63:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,

	output ccm_req_t    req
);

	logic      awready_q;
	logic      wready_q;
	logic      bvalid_q;
	logic      arready_q;
	logic      rvalid_q;
	logic      wr_open; // Write accepted, B not yet taken.
	ccm_addr_u aw_addr;
	ccm_addr_u ar_addr;
	logic      wr_start;
	logic      rd_start;
	logic      wen;
	logic      ren;

	// A write starts once AW and W are both present.
	assign wr_start = ~wr_open & awvalid & wvalid;

	// Read waits a cycle when a write starts alongside it.
	assign rd_start = ~arready_q & ~rvalid_q & arvalid & ~wr_start;

	assign wen = awready_q & awvalid & wready_q & wvalid; // One hit per write.
	assign ren = arready_q & arvalid;                      // One hit per read.

	always_ff @(posedge CLK) begin
		if (reset) begin
			awready_q <= 1'b0;
			wready_q  <= 1'b0;
			bvalid_q  <= 1'b0;
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
			wr_open   <= 1'b0;
		end else begin
			awready_q <= wr_start; // Single cycle pulse.
			wready_q  <= wr_start;
			arready_q <= rd_start;

			if (wr_start)
				wr_open <= 1'b1;
			else if (bvalid_q & bready)
				wr_open <= 1'b0;

			if (wen)
				bvalid_q <= 1'b1;
			else if (bready)
				bvalid_q <= 1'b0;

			// Held until taken, so RDATA stays put under back-pressure.
			if (ren)
				rvalid_q <= 1'b1;
			else if (rready)
				rvalid_q <= 1'b0;
		end
	end

	// Address capture.
	always_ff @(posedge CLK) begin
		if (wr_start)
			aw_addr.flat <= awaddr;
		if (rd_start)
			ar_addr.flat <= araddr;
	end

	always_comb begin
		req.addr  = wen ? aw_addr : ar_addr; // wen and ren never overlap.
		req.wdata = wdata;
		req.wstrb = wstrb;
		req.wen   = wen;
		req.ren   = ren;
	end

	assign awready = awready_q;
	assign wready  = wready_q;
	assign bresp   = 2'b00;
	assign bvalid  = bvalid_q;
	assign arready = arready_q;
	assign rresp   = 2'b00;
	assign rvalid  = rvalid_q;

endmodule

// File: hdl/ccm_lane_align.sv
// Splits a 64-bit access at any byte address over the even and odd banks; read merge lags ren by one cycle.
module ccm_lane_align
	import ccm_pkg::*;
(
	input  logic          CLK,
	input  logic          reset,
	input  ccm_req_t      req,
	output ccm_bank_req_t even_req,
	output ccm_bank_req_t odd_req,
	input  logic [63:0]   even_rdata,
	input  logic [63:0]   odd_rdata,
	output logic [63:0]   rdata
);

	ccm_addr_u            addr;
	logic [5:0]           wshift;
	logic [127:0]         wwin;
	logic [15:0]          swin;
	logic [ccm_row_w-1:0] row_next;
	logic [2:0]           rd_offset;
	logic                 rd_bank;
	logic [127:0]         rwin;

	assign addr     = req.addr;
	assign wshift   = {addr.f.offset, 3'b000};
	assign row_next = addr.f.row + 1'b1;

	// Rotate data and strobes into a two-word window.
	assign wwin = {64'd0, req.wdata} << wshift;
	assign swin = {8'd0, req.wstrb} << addr.f.offset;

	always_comb begin
		// Odd bank always uses the row of the address.
		odd_req.row    = addr.f.row;
		odd_req.wdata  = addr.f.bank ? wwin[63:0] : wwin[127:64];
		odd_req.wstrb  = addr.f.bank ? swin[7:0] : swin[15:8];
		odd_req.wen    = req.wen;
		odd_req.ren    = req.ren;

		// Even word after an odd start sits one row up.
		even_req.row   = addr.f.bank ? row_next : addr.f.row;
		even_req.wdata = addr.f.bank ? wwin[127:64] : wwin[63:0];
		even_req.wstrb = addr.f.bank ? swin[15:8] : swin[7:0];
		even_req.wen   = req.wen;
		even_req.ren   = req.ren;
	end

	// Keep the lane order of the read until the banks answer.
	always_ff @(posedge CLK) begin
		if (reset) begin
			rd_offset <= 3'd0;
			rd_bank   <= 1'b0;
		end else if (req.ren) begin
			rd_offset <= addr.f.offset;
			rd_bank   <= addr.f.bank;
		end
	end

	// First word in the low half.
	assign rwin  = rd_bank ? {even_rdata, odd_rdata} : {odd_rdata, even_rdata};
	assign rdata = rwin[{rd_offset, 3'b000} +: 64];

endmodule

// File: hdl/ccm_bank.sv
// One bank of ccm_depth 64-bit words; contents undefined after power-up, read data held between reads.
module ccm_bank
	import ccm_pkg::*;
(
	input  logic          CLK,
	input  ccm_bank_req_t breq,
	output logic [63:0]   rdata
);

	logic [63:0] mem [0:ccm_depth-1];

	// Byte writes under strobe.
	always_ff @(posedge CLK) begin
		if (breq.wen) begin
			for (int i = 0; i < 8; i++) begin
				if (breq.wstrb[i])
					mem[breq.row][i*8 +: 8] <= breq.wdata[i*8 +: 8];
			end
		end
	end

	// Registered read.
	always_ff @(posedge CLK) begin
		if (breq.ren)
			rdata <= mem[breq.row]; // Old data on a same-cycle write.
	end

endmodule

// File: hdl/ccm_top.sv
// CCM top: AXI4-Lite slave, lane aligner and two word banks; unaligned access costs no extra cycle.
module ccm_top
	import ccm_pkg::*;
(
	input  logic        CLK,
	input  logic        reset,

	input  logic [63:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [63:0] wdata,
	input  logic [7:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,

	input  logic [63:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [63:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);

	ccm_req_t      req;
	ccm_bank_req_t even_req;
	ccm_bank_req_t odd_req;
	logic [63:0]   even_rdata;
	logic [63:0]   odd_rdata;

	ccm_axi_slave u_slave (
		.CLK     (CLK),
		.reset   (reset),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.req     (req)
	);

	ccm_lane_align u_align (
		.CLK        (CLK),
		.reset      (reset),
		.req        (req),
		.even_req   (even_req),
		.odd_req    (odd_req),
		.even_rdata (even_rdata),
		.odd_rdata  (odd_rdata),
		.rdata      (rdata)
	);

	ccm_bank u_bank_even (
		.CLK   (CLK),
		.breq  (even_req),
		.rdata (even_rdata)
	);

	ccm_bank u_bank_odd (
		.CLK   (CLK),
		.breq  (odd_req),
		.rdata (odd_rdata)
	);

endmodule

// File: bench/ccm_properties.sv
// Handshake and response checks for ccm_top; assumes the master keeps valid and payload stable until ready.
module ccm_properties (
	input logic        CLK,
	input logic        reset,
	input logic        awvalid,
	input logic        awready,
	input logic        wvalid,
	input logic        wready,
	input logic [1:0]  bresp,
	input logic        bvalid,
	input logic        bready,
	input logic        arvalid,
	input logic        arready,
	input logic [1:0]  rresp,
	input logic        rvalid,
	input logic        rready,
	input logic [63:0] rdata
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// Slave side of every channel idle out of reset.
	reset_state: assert property (@(posedge CLK)
		reset |=> !awready && !wready && !bvalid && !arready && !rvalid)
		else begin
			fail_count++;
			$error("handshake outputs not low after reset");
		end

	// AWREADY and WREADY as one single cycle pulse.
	ready_pulse: assert property (@(posedge CLK) disable iff (reset)
		awready |-> wready ##1 !awready && !wready)
		else begin
			fail_count++;
			$error("AWREADY and WREADY not a shared one cycle pulse");
		end

	ready_cause: assert property (@(posedge CLK) disable iff (reset)
		$rose(awready) |-> $past(awvalid && wvalid))
		else begin
			fail_count++;
			$error("AWREADY rose without both AWVALID and WVALID the cycle before");
		end

	b_follows: assert property (@(posedge CLK) disable iff (reset)
		awready && awvalid && wready && wvalid |=> bvalid)
		else begin
			fail_count++;
			$error("BVALID missing the cycle after the write handshake");
		end

	b_holds: assert property (@(posedge CLK) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else begin
			fail_count++;
			$error("BVALID dropped before BREADY");
		end

	r_follows: assert property (@(posedge CLK) disable iff (reset)
		arready && arvalid |=> rvalid)
		else begin
			fail_count++;
			$error("RVALID missing the cycle after the AR handshake");
		end

	// Read data frozen under back-pressure.
	r_holds: assert property (@(posedge CLK) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin
			fail_count++;
			$error("RVALID or RDATA changed while RREADY was low");
		end

	ar_blocked: assert property (@(posedge CLK) disable iff (reset)
		!(arready && rvalid))
		else begin
			fail_count++;
			$error("ARREADY high while RVALID high");
		end

	// Both responses always OKAY.
	resp_okay: assert property (@(posedge CLK) disable iff (reset)
		(!bvalid || bresp == 2'b00) && (!rvalid || rresp == 2'b00))
		else begin
			fail_count++;
			$error("BRESP or RRESP not OKAY while valid");
		end

endmodule

bind ccm_top ccm_properties u_props (.*);

// File: bench/ccm_tb.sv
// Testbench for ccm_top; accesses stay in a 512-byte window and run one at a time except the overlap cases.
module ccm_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int span         = 512; // Bytes tracked by the shadow.
	localparam int limit_cycles = 50;

	logic        CLK;
	logic        reset;
	logic [63:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [63:0] wdata;
	logic [7:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [63:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [63:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	logic [7:0]  shadow [0:span-1];
	logic [63:0] expect_data;
	int          expect_addr;
	int          errors;
	int          reads_done;

	ccm_top uut (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Every R handshake returns the eight shadow bytes at the read address.
	rdata_check: assert property (@(posedge CLK) disable iff (reset)
		rvalid && rready |-> rdata == expect_data)
		else begin
			errors++;
			$display("CHECK FAILED at %0t: read at %h gave %h, expected %h",
				$time, expect_addr, $sampled(rdata), expect_data);
		end

	function automatic logic [63:0] shadow_word(input int addr);
		logic [63:0] w;
		for (int i = 0; i < 8; i++)
			w[i*8 +: 8] = shadow[addr + i]; // Little endian.
		return w;
	endfunction

	task automatic step_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic axi_write(input int addr, input logic [63:0] data, input logic [7:0] strb);
		int waited;
		for (int i = 0; i < 8; i++)
			if (strb[i])
				shadow[addr + i] = data[i*8 +: 8];
		awaddr  = 64'(addr);
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		waited  = 0;
		while (!(awready && wready) && waited < limit_cycles) begin
			step_cycle();
			waited++;
		end
		if (!(awready && wready)) begin
			errors++;
			$display("Timed out at %0t waiting for AWREADY and WREADY, address %h", $time, addr);
		end
		step_cycle(); // Handshake edge.
		awvalid = 1'b0;
		wvalid  = 1'b0;
		repeat ($urandom_range(3, 0)) step_cycle();
		bready = 1'b1;
		waited = 0;
		while (!bvalid && waited < limit_cycles) begin
			step_cycle();
			waited++;
		end
		if (!bvalid) begin
			errors++;
			$display("Timed out at %0t waiting for BVALID, address %h", $time, addr);
		end else
			step_cycle();
		bready = 1'b0;
	endtask

	task automatic axi_read(input int addr);
		int waited;
		araddr  = 64'(addr);
		arvalid = 1'b1;
		waited  = 0;
		while (!arready && waited < limit_cycles) begin
			step_cycle();
			waited++;
		end
		if (!arready) begin
			errors++;
			$display("Timed out at %0t waiting for ARREADY, address %h", $time, addr);
			arvalid = 1'b0;
			return;
		end
		expect_data = shadow_word(addr); // A write that won the tie is already in.
		expect_addr = addr;
		step_cycle();
		arvalid = 1'b0;
		repeat ($urandom_range(3, 0)) step_cycle(); // R back-pressure.
		rready = 1'b1;
		waited = 0;
		while (!rvalid && waited < limit_cycles) begin
			step_cycle();
			waited++;
		end
		if (!rvalid) begin
			errors++;
			$display("Timed out at %0t waiting for RVALID, address %h", $time, addr);
		end else begin
			step_cycle();
			reads_done++;
		end
		rready = 1'b0;
	endtask

	// Keeps the next AR valid while the first R waits for RREADY.
	task automatic read_with_ar_queued(input int first, input int second);
		int waited;
		araddr  = 64'(first);
		arvalid = 1'b1;
		waited  = 0;
		while (!arready && waited < limit_cycles) begin
			step_cycle();
			waited++;
		end
		if (!arready) begin
			errors++;
			$display("Timed out at %0t waiting for ARREADY, address %h", $time, first);
			arvalid = 1'b0;
			return;
		end
		expect_data = shadow_word(first);
		expect_addr = first;
		step_cycle();
		araddr = 64'(second); // Second AR pending behind RVALID.
		repeat (3) step_cycle();
		rready = 1'b1;
		waited = 0;
		while (!rvalid && waited < limit_cycles) begin
			step_cycle();
			waited++;
		end
		if (!rvalid) begin
			errors++;
			$display("Timed out at %0t waiting for RVALID, address %h", $time, first);
		end else begin
			step_cycle();
			reads_done++;
		end
		rready = 1'b0;
		axi_read(second);
	endtask

	initial begin
		int addr;
		void'($urandom(32'h17f2_3670));
		errors      = 0;
		reads_done  = 0;
		expect_data = '0;
		expect_addr = 0;
		reset   = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (10) @(posedge CLK);
		#1;
		reset = 1'b0;

		// Known pattern, aligned, full strobes.
		for (int a = 0; a < span; a += 8)
			axi_write(a, {~32'(a), 32'(a) * 32'h9e37_79b9}, 8'hff);
		for (int a = 0; a < 64; a += 8)
			axi_read(a);

		// Odd bank start with a line crossing, then the even row plus one case.
		axi_write(13, 64'h0123_4567_89ab_cdef, 8'ha5);
		axi_read(13);
		axi_read(8);
		axi_read(16);
		axi_write(31, 64'hfedc_ba98_7654_3210, 8'hff);
		axi_read(27);
		axi_read(31);

		// Next AR raised while RVALID waits for RREADY.
		read_with_ar_queued(13, 31);
		read_with_ar_queued(40, 5);

		for (int n = 0; n < 300; n++) begin
			addr = $urandom_range(span - 8, 0);
			if ($urandom_range(1, 0) == 1)
				axi_write(addr, {$urandom, $urandom}, 8'($urandom));
			else
				axi_read(addr);
		end

		// AW, W and AR in the same cycle.
		for (int n = 0; n < 4; n++) begin
			addr = $urandom_range(span - 8, 0);
			fork
				axi_write(addr, {$urandom, $urandom}, 8'($urandom));
				axi_read(addr);
			join
		end

		repeat (5) step_cycle();
		$display("Summary: %0d reads, %0d bench errors, %0d property failures",
			reads_done, errors, uut.u_props.fail_count);
		if (errors == 0 && uut.u_props.fail_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: ccm_top.f
hdl/ccm_pkg.sv
hdl/ccm_axi_slave.sv
hdl/ccm_lane_align.sv
hdl/ccm_bank.sv
hdl/ccm_top.sv
bench/ccm_properties.sv
bench/ccm_tb.sv
